// ==== mem_pkg.sv ====
// shared widths, access encodings and result selects for the memory and writeback stages
package mem_pkg;

	// ------------------------------------------------------------------
	// data path widths
	// ------------------------------------------------------------------

	localparam int data_w     = 32;   // integer data path and address width
	localparam int byte_w     = 8;    // one memory lane
	localparam int half_w     = 16;   // two lanes, a halfword access
	localparam int byte_off_w = 2;    // address bits that pick a byte inside a word
	localparam int lanes      = data_w / byte_w;   // byte lanes per memory word
	localparam int reg_addr_w = 5;    // 32 architectural registers

	// every data word, address and register-file result uses this type
	typedef logic [data_w-1:0] word_t;

	// destination register index, register 0 is hardwired to zero in the register file
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// one write strobe per byte lane, bit 0 is the lane at the lowest address
	typedef logic [lanes-1:0] byte_en_t;

	// byte offset of an access inside its word
	typedef logic [byte_off_w-1:0] byte_off_t;

	// ------------------------------------------------------------------
	// access type of a load or store
	// ------------------------------------------------------------------

	// the u variants zero-extend a load, the others sign-extend it
	// stores only look at the width and treat acc_bu like acc_b
	typedef enum logic [2:0] {
		acc_b  = 3'd0,    // signed byte
		acc_bu = 3'd1,    // unsigned byte
		acc_h  = 3'd2,    // signed halfword
		acc_hu = 3'd3,    // unsigned halfword
		acc_w  = 3'd4     // full word, no extension needed
	} access_t;

	// ------------------------------------------------------------------
	// source of the register-file write data
	// ------------------------------------------------------------------

	// zero encoding is the ALU result so a squashed slot writes back a plain zero
	typedef enum logic [1:0] {
		sel_alu  = 2'd0,  // arithmetic or logic result
		sel_load = 2'd1,  // aligned and extended load data
		sel_imm  = 2'd2,  // immediate, as for lui
		sel_pc4  = 2'd3   // return address of a jump and link
	} wb_sel_t;

endpackage

// ==== mem_ifs.sv ====
// bundles between the memory stage, the data memory and the writeback stage inside mem_wb_top

// ----------------------------------------------------------------------
// memory request and read data
// ----------------------------------------------------------------------

// the stage drives a request every cycle, the memory answers one edge later
interface mem_req_if;

	mem_pkg::word_t    addr;      // byte address straight from the ALU
	mem_pkg::word_t    wdata;     // store data already replicated into its lanes
	mem_pkg::byte_en_t byte_en;   // lanes written by a store
	logic              we;        // store this cycle
	logic              re;        // load this cycle
	mem_pkg::word_t    rdata;     // whole word, registered at the edge after re

	// the memory stage only issues requests
	modport stage (
		output addr,
		output wdata,
		output byte_en,
		output we,
		output re
	);

	modport memory (
		input  addr,
		input  wdata,
		input  byte_en,
		input  we,
		input  re,
		output rdata
	);

	// writeback only sees the returned word and picks its lanes itself
	modport reader (
		input rdata
	);

endinterface

// ----------------------------------------------------------------------
// registered writeback bundle
// ----------------------------------------------------------------------

interface wb_bundle_if;

	mem_pkg::word_t     alu_result;   // also holds the access address of a load
	mem_pkg::word_t     imm;
	mem_pkg::word_t     pc4;
	mem_pkg::access_t   access;       // tells writeback how to align and extend
	mem_pkg::wb_sel_t   wb_sel;
	mem_pkg::reg_addr_t rd_addr;
	logic               rd_we;

	modport source (
		output alu_result, imm, pc4, access, wb_sel, rd_addr, rd_we
	);

	modport sink (
		input alu_result, imm, pc4, access, wb_sel, rd_addr, rd_we
	);

endinterface

// ==== mem_stage.sv ====
// memory pipeline stage that issues the data memory request and registers the writeback bundle
module mem_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               enb,          // level, the stage advances at the next edge
	input  logic               kill,         // pulse, squashes the instruction in this slot
	input  mem_pkg::word_t     cache_limit,  // addresses above this one are cacheable
	input  mem_pkg::word_t     alu_result,
	input  mem_pkg::word_t     wdata,
	input  mem_pkg::word_t     imm,
	input  mem_pkg::word_t     pc4,
	input  mem_pkg::access_t   access,
	input  mem_pkg::wb_sel_t   wb_sel,
	input  mem_pkg::reg_addr_t rd_addr,
	input  logic               rd_we,
	input  logic               is_load,
	input  logic               is_store,
	input  logic               bypass,       // store data comes from the writeback result
	input  mem_pkg::word_t     wb_result,    // result of the instruction now in writeback
	mem_req_if.stage           req,
	wb_bundle_if.source        wb,
	output logic               cacheable
);

	logic               go;          // a real access may reach the memory this cycle
	mem_pkg::word_t     store_data;  // store data before it is spread over the lanes
	mem_pkg::byte_off_t addr_off;    // byte offset of the access inside its word

	assign go       = enb && !kill;
	assign addr_off = alu_result[mem_pkg::byte_off_w-1:0];

	// the previous result is still on rd_data, so a dependent store needs no stall
	assign store_data = bypass ? wb_result : wdata;

	// ------------------------------------------------------------------
	// memory request, combinational so that the read returns with the bundle
	// ------------------------------------------------------------------

	assign req.addr = alu_result;           // the memory drops the offset bits itself
	assign req.re   = is_load && go;        // a held or squashed slot never touches memory
	assign req.we   = is_store && go;

	// narrow stores copy their data into every lane and let the strobes pick one
	always_comb begin
		case (access)
			mem_pkg::acc_b, mem_pkg::acc_bu: begin
				req.wdata   = {mem_pkg::lanes{store_data[mem_pkg::byte_w-1:0]}};
				req.byte_en = mem_pkg::byte_en_t'(4'b0001 << addr_off);
			end
			mem_pkg::acc_h, mem_pkg::acc_hu: begin
				req.wdata   = {2{store_data[mem_pkg::half_w-1:0]}};
				req.byte_en = mem_pkg::byte_en_t'(4'b0011 << {addr_off[1], 1'b0});
			end
			default: begin
				req.wdata   = store_data;   // word store uses all four lanes
				req.byte_en = '1;
			end
		endcase
	end

	// ------------------------------------------------------------------
	// writeback bundle and cacheable flag
	// ------------------------------------------------------------------

	// kill clears the slot even while the stage is stalled
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb.alu_result <= '0;
			wb.imm        <= '0;
			wb.pc4        <= '0;
			wb.access     <= mem_pkg::acc_b;
			wb.wb_sel     <= mem_pkg::sel_alu;
			wb.rd_addr    <= '0;
			wb.rd_we      <= 1'b0;
			cacheable     <= 1'b0;
		end else if (kill) begin
			wb.alu_result <= '0;
			wb.imm        <= '0;
			wb.pc4        <= '0;
			wb.access     <= mem_pkg::acc_b;
			wb.wb_sel     <= mem_pkg::sel_alu;  // a squashed slot writes back zero
			wb.rd_addr    <= '0;
			wb.rd_we      <= 1'b0;
			cacheable     <= 1'b0;
		end else if (enb) begin
			wb.alu_result <= alu_result;
			wb.imm        <= imm;
			wb.pc4        <= pc4;
			wb.access     <= access;
			wb.wb_sel     <= wb_sel;
			wb.rd_addr    <= rd_addr;
			wb.rd_we      <= rd_we;
			cacheable     <= alu_result > cache_limit;  // strictly above the boundary
		end
	end

	// there is no misaligned trap, so the memory would silently access the wrong lanes
	a_half_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		(req.re || req.we) && (access inside {mem_pkg::acc_h, mem_pkg::acc_hu})
		|-> !addr_off[0])
		else $error("misaligned halfword access at %h", alu_result);

	a_word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		(req.re || req.we) && (access == mem_pkg::acc_w) |-> (addr_off == '0))
		else $error("misaligned word access at %h", alu_result);

	// decode never marks one instruction as both
	a_load_xor_store: assert property (@(posedge clk) disable iff (!arst_n)
		!(is_load && is_store))
		else $error("load and store flagged in the same slot");

endmodule

// ==== data_mem.sv ====
// word-wide data memory with byte write strobes and a one-cycle registered read
module data_mem #(
	parameter int mem_words = 256   // depth in 32-bit words
) (
	input  logic      clk,
	mem_req_if.memory port
);

	localparam int idx_w = $clog2(mem_words);   // width of the word index

	mem_pkg::word_t   mem_array [mem_words];    // contents survive reset
	logic [idx_w-1:0] idx;                      // word selected by the request

	// the byte offset bits were already turned into strobes by the stage
	assign idx = port.addr[mem_pkg::byte_off_w +: idx_w];

	// ------------------------------------------------------------------
	// write port
	// ------------------------------------------------------------------

	// only the strobed lanes change, the rest of the word keeps its value
	always_ff @(posedge clk) begin
		if (port.we) begin
			for (int i = 0; i < mem_pkg::lanes; i++) begin
				if (port.byte_en[i]) begin
					mem_array[idx][i*mem_pkg::byte_w +: mem_pkg::byte_w] <=
						port.wdata[i*mem_pkg::byte_w +: mem_pkg::byte_w];
				end
			end
		end
	end

	// ------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------

	// the whole word is returned and writeback picks the lanes
	// rdata keeps the last word while no load is issued, so a stalled load still sees it
	always_ff @(posedge clk) begin
		if (port.re) begin
			port.rdata <= mem_array[idx];
		end
	end

	// an address past the end would wrap onto a lower word without any error
	a_in_range: assert property (@(posedge clk)
		(port.we || port.re)
		|-> (port.addr[mem_pkg::data_w-1:mem_pkg::byte_off_w] < mem_words))
		else $error("data memory access at %h is beyond %0d words", port.addr, mem_words);

endmodule

// ==== wb_stage.sv ====
// writeback stage that aligns and extends load data and selects the register-file result
module wb_stage (
	wb_bundle_if.sink          wb,
	mem_req_if.reader          mem,
	output logic               rd_we,
	output mem_pkg::reg_addr_t rd_addr,
	output mem_pkg::word_t     rd_data
);

	mem_pkg::byte_off_t          off;        // byte offset of the load that fetched rdata
	logic [mem_pkg::byte_w-1:0]  ld_byte;    // addressed byte of the returned word
	logic [mem_pkg::half_w-1:0]  ld_half;    // addressed halfword of the returned word
	mem_pkg::word_t              load_data;  // load result after extension

	// the load address travels in the bundle as the ALU result
	assign off = wb.alu_result[mem_pkg::byte_off_w-1:0];

	// ------------------------------------------------------------------
	// load alignment
	// ------------------------------------------------------------------

	assign ld_byte = mem.rdata[{off, 3'b000} +: mem_pkg::byte_w];
	assign ld_half = mem.rdata[{off[1], 4'b0000} +: mem_pkg::half_w];   // even offsets only

	always_comb begin
		case (wb.access)
			mem_pkg::acc_b: begin
				load_data = {{(mem_pkg::data_w-mem_pkg::byte_w){ld_byte[mem_pkg::byte_w-1]}},
					ld_byte};
			end
			mem_pkg::acc_bu: begin
				load_data = {{(mem_pkg::data_w-mem_pkg::byte_w){1'b0}}, ld_byte};
			end
			mem_pkg::acc_h: begin
				load_data = {{(mem_pkg::data_w-mem_pkg::half_w){ld_half[mem_pkg::half_w-1]}},
					ld_half};
			end
			mem_pkg::acc_hu: begin
				load_data = {{(mem_pkg::data_w-mem_pkg::half_w){1'b0}}, ld_half};
			end
			default: begin
				load_data = mem.rdata;   // word load needs neither shift nor extension
			end
		endcase
	end

	// ------------------------------------------------------------------
	// result select
	// ------------------------------------------------------------------

	always_comb begin
		case (wb.wb_sel)
			mem_pkg::sel_load: rd_data = load_data;
			mem_pkg::sel_imm:  rd_data = wb.imm;
			mem_pkg::sel_pc4:  rd_data = wb.pc4;
			default:           rd_data = wb.alu_result;   // sel_alu and a cleared slot
		endcase
	end

	assign rd_we   = wb.rd_we;     // the register file writes at the next edge
	assign rd_addr = wb.rd_addr;

	// x0 is hardwired to zero, so decode must drop rd_we for it before the memory stage
	a_no_x0_write: assert final (!(rd_we === 1'b1 && rd_addr == '0))
		else $error("register file write to x0 reached writeback");

endmodule

// ==== mem_wb_top.sv ====
// memory and writeback end of the integer pipeline, instantiated by the testbench as the DUT
module mem_wb_top #(
	parameter int mem_words = 256   // data memory depth in words
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               enb,
	input  logic               kill,
	input  mem_pkg::word_t     cache_limit,
	input  mem_pkg::word_t     alu_result,
	input  mem_pkg::word_t     wdata,
	input  mem_pkg::word_t     imm,
	input  mem_pkg::word_t     pc4,
	input  mem_pkg::access_t   access,
	input  mem_pkg::wb_sel_t   wb_sel,
	input  mem_pkg::reg_addr_t ex_rd_addr,   // destination coming from execute
	input  logic               ex_rd_we,
	input  logic               is_load,
	input  logic               is_store,
	input  logic               bypass,
	output logic               rd_we,        // register-file write port
	output mem_pkg::reg_addr_t rd_addr,
	output mem_pkg::word_t     rd_data,
	output logic               cacheable
);

	mem_req_if   req_bus ();   // request from the stage, read word to writeback
	wb_bundle_if wb_bus ();    // registered bundle between the two stages

	// rd_data goes back as wb_result to close the store bypass path
	mem_stage u_mem_stage (
		.clk         (clk),
		.arst_n      (arst_n),
		.enb         (enb),
		.kill        (kill),
		.cache_limit (cache_limit),
		.alu_result  (alu_result),
		.wdata       (wdata),
		.imm         (imm),
		.pc4         (pc4),
		.access      (access),
		.wb_sel      (wb_sel),
		.rd_addr     (ex_rd_addr),
		.rd_we       (ex_rd_we),
		.is_load     (is_load),
		.is_store    (is_store),
		.bypass      (bypass),
		.wb_result   (rd_data),
		.req         (req_bus.stage),
		.wb          (wb_bus.source),
		.cacheable   (cacheable)
	);

	data_mem #(
		.mem_words (mem_words)
	) u_data_mem (
		.clk  (clk),
		.port (req_bus.memory)
	);

	wb_stage u_wb_stage (
		.wb      (wb_bus.sink),
		.mem     (req_bus.reader),
		.rd_we   (rd_we),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// ==== tb_mem_wb_ref.svh ====
// reference model of mem_wb_top, included by the testbench after its stimulus signals
`ifndef tb_mem_wb_ref_svh
`define tb_mem_wb_ref_svh

mem_pkg::word_t     shadow [region_words];   // the tests never leave this region
logic               exp_rd_we = 1'b0;
mem_pkg::reg_addr_t exp_rd_addr = '0;
mem_pkg::word_t     exp_rd_data = '0;        // also the value a bypassed store writes
logic               exp_cacheable = 1'b0;

// picks the addressed byte or half out of a word and extends it
function automatic mem_pkg::word_t load_value(input mem_pkg::word_t w, input logic [1:0] off,
		input mem_pkg::access_t acc);
	logic [7:0]  b;
	logic [15:0] h;
	b = 8'(w >> (8 * off));
	h = 16'(w >> (8 * off));
	case (acc)
		mem_pkg::acc_b:  return 32'($signed(b));
		mem_pkg::acc_bu: return 32'(b);
		mem_pkg::acc_h:  return 32'($signed(h));
		mem_pkg::acc_hu: return 32'(h);
		default:         return w;
	endcase
endfunction

// a store only replaces the lanes it covers, the sign variants write the same way
function automatic mem_pkg::word_t store_merge(input mem_pkg::word_t old,
		input mem_pkg::word_t data, input logic [1:0] off, input mem_pkg::access_t acc);
	mem_pkg::word_t w;
	w = old;
	case (acc)
		mem_pkg::acc_b, mem_pkg::acc_bu: w[8*off +: 8] = data[7:0];
		mem_pkg::acc_h, mem_pkg::acc_hu: w[8*off +: 16] = data[15:0];
		default:                         w = data;
	endcase
	return w;
endfunction

// ----------------------------------------------------------------------
// one clock edge, using the inputs the DUT samples at that edge
// ----------------------------------------------------------------------

function automatic void predict_edge();
	int unsigned    idx;
	mem_pkg::word_t sdata;
	idx = int'(alu_result >> 2);   // only used by loads and stores
	if (kill) begin
		exp_rd_we     = 1'b0;      // kill wins over enb and clears everything
		exp_rd_addr   = '0;
		exp_rd_data   = '0;
		exp_cacheable = 1'b0;
	end else if (enb) begin
		if (is_store) begin
			sdata       = bypass ? exp_rd_data : wdata;   // rd_data of the slot ahead
			shadow[idx] = store_merge(shadow[idx], sdata, alu_result[1:0], access);
		end
		exp_rd_we     = ex_rd_we;
		exp_rd_addr   = ex_rd_addr;
		exp_cacheable = alu_result > cache_limit;
		case (wb_sel)
			mem_pkg::sel_load: exp_rd_data = load_value(shadow[idx], alu_result[1:0], access);
			mem_pkg::sel_imm:  exp_rd_data = imm;
			mem_pkg::sel_pc4:  exp_rd_data = pc4;
			default:           exp_rd_data = alu_result;
		endcase
	end
	// enb low and kill low leaves every expected output where it was
endfunction

`endif

// ==== tb_mem_wb_top.sv ====
// self-checking testbench for mem_wb_top, compiled with the project file list as top module
module tb_mem_wb_top;

	localparam int region_words = 64;   // all words written by the word test before any load
	localparam int sub_words    = 8;    // words that get byte and half accesses
	// every test plus its two flush cycles, then a margin
	localparam int cycle_limit = 7 + 130 + (sub_words * 21 + 2) + 42 + 22 + 32 + 32 + 402 + 100;

	logic               clk;
	logic               arst_n = 1'b0;
	logic               enb = 1'b0;
	logic               kill = 1'b0;
	mem_pkg::word_t     cache_limit = '0;
	mem_pkg::word_t     alu_result = '0;
	mem_pkg::word_t     wdata = '0;
	mem_pkg::word_t     imm = '0;
	mem_pkg::word_t     pc4 = '0;
	mem_pkg::access_t   access = mem_pkg::acc_w;
	mem_pkg::wb_sel_t   wb_sel = mem_pkg::sel_alu;
	mem_pkg::reg_addr_t ex_rd_addr = '0;
	logic               ex_rd_we = 1'b0;
	logic               is_load = 1'b0;
	logic               is_store = 1'b0;
	logic               bypass = 1'b0;
	logic               rd_we;
	mem_pkg::reg_addr_t rd_addr;
	mem_pkg::word_t     rd_data;
	logic               cacheable;

	integer         seed = 32'h71ad;
	mem_pkg::word_t limit_val = 32'h80;   // boundary lies inside the memory region
	int             errors = 0;
	int             test_start = 0;
	int             tests_run = 0;
	int             tests_failed = 0;
	int             cycles = 0;
	string          test_name = "reset";
	logic           check_en = 1'b0;

	`include "tb_mem_wb_ref.svh"

	mem_wb_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// the model steps at the same edges as the DUT registers
	always @(posedge clk) begin
		if (!arst_n) begin
			exp_rd_we     = 1'b0;
			exp_rd_addr   = '0;
			exp_rd_data   = '0;
			exp_cacheable = 1'b0;
		end else begin
			predict_edge();
		end
	end

	task automatic report_mismatch(input string sig, input mem_pkg::word_t exp_v,
			input mem_pkg::word_t act_v);
		$display("Mismatch %s %s expected %h actual %h", test_name, sig, exp_v, act_v);
		errors++;
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (check_en) begin
			assert (rd_we === exp_rd_we) else report_mismatch("rd_we", exp_rd_we, rd_we);
			assert (rd_addr === exp_rd_addr)
				else report_mismatch("rd_addr", exp_rd_addr, rd_addr);
			assert (rd_data === exp_rd_data)
				else report_mismatch("rd_data", exp_rd_data, rd_data);
			assert (cacheable === exp_cacheable)
				else report_mismatch("cacheable", exp_cacheable, cacheable);
		end
	end

	initial begin
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycles);
		$display("TEST FAILED");
		$finish;
	end

	// one instruction presented to the DUT for the next edge
	task automatic send(input logic en, input logic kl, input logic ld, input logic st,
			input logic byp, input mem_pkg::access_t acc, input mem_pkg::wb_sel_t sel,
			input mem_pkg::word_t addr, input mem_pkg::word_t data);
		mem_pkg::reg_addr_t rd;
		rd = mem_pkg::reg_addr_t'($random(seed));
		if (rd == '0) begin
			rd = 5'd1;   // x0 is never a destination
		end
		@(posedge clk);
		enb         <= en;
		kill        <= kl;
		is_load     <= ld;
		is_store    <= st;
		bypass      <= byp;
		access      <= acc;
		wb_sel      <= sel;
		alu_result  <= addr;
		wdata       <= data;
		ex_rd_we    <= !st;
		ex_rd_addr  <= rd;
		imm         <= $random(seed);
		pc4         <= $random(seed);
		cache_limit <= limit_val;
	endtask

	task automatic begin_test(input string name);
		test_name  = name;
		test_start = errors;
	endtask

	task automatic end_test();
		send(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, mem_pkg::acc_w, mem_pkg::sel_alu, '0, '0);
		@(posedge clk);   // the last instruction has been checked by now
		tests_run++;
		if (errors != test_start) begin
			tests_failed++;
		end
		$display("test %s finished with %0d errors", test_name, errors - test_start);
	endtask

	initial begin
		mem_pkg::word_t   a;
		mem_pkg::word_t   d;
		logic [31:0]      r;
		mem_pkg::access_t acc;
		mem_pkg::wb_sel_t sel;
		repeat (3) @(posedge clk);
		arst_n   <= 1'b1;
		check_en <= 1'b1;
		repeat (2) @(posedge clk);
		assert (rd_we === 1'b0 && cacheable === 1'b0) else begin
			$display("rd_we or cacheable was active after reset without an enabled edge");
			errors++;
		end
		end_test();

		// ------------------------------------------------------------------
		// directed tests
		// ------------------------------------------------------------------

		begin_test("word");
		for (int i = 0; i < region_words; i++)
			send(1, 0, 0, 1, 0, mem_pkg::acc_w, mem_pkg::sel_alu, i * 4, $random(seed));
		for (int i = 0; i < region_words; i++)
			send(1, 0, 1, 0, 0, mem_pkg::acc_w, mem_pkg::sel_load, i * 4, '0);
		end_test();

		begin_test("subword");
		for (int w = 0; w < sub_words; w++) begin
			for (int o = 0; o < 4; o++) begin
				d    = $random(seed);
				d[7] = o[0] ^ w[0];   // both signs show up at every offset
				send(1, 0, 0, 1, 0, mem_pkg::acc_b, mem_pkg::sel_alu, w * 4 + o, d);
				send(1, 0, 1, 0, 0, mem_pkg::acc_b, mem_pkg::sel_load, w * 4 + o, '0);
				send(1, 0, 1, 0, 0, mem_pkg::acc_bu, mem_pkg::sel_load, w * 4 + o, '0);
			end
			send(1, 0, 1, 0, 0, mem_pkg::acc_w, mem_pkg::sel_load, w * 4, '0);
			for (int o = 0; o < 4; o += 2) begin
				d     = $random(seed);
				d[15] = o[1] ^ w[0];
				send(1, 0, 0, 1, 0, mem_pkg::acc_hu, mem_pkg::sel_alu, w * 4 + o, d);
				send(1, 0, 1, 0, 0, mem_pkg::acc_h, mem_pkg::sel_load, w * 4 + o, '0);
				send(1, 0, 1, 0, 0, mem_pkg::acc_hu, mem_pkg::sel_load, w * 4 + o, '0);
				send(1, 0, 1, 0, 0, mem_pkg::acc_w, mem_pkg::sel_load, w * 4, '0);
			end
		end
		end_test();

		begin_test("select");
		for (int i = 0; i < 40; i++) begin
			a         = $random(seed);
			limit_val = (i % 8 == 0) ? a : $random(seed);   // equal is not cacheable
			sel = (i % 3 == 0) ? mem_pkg::sel_alu :
				(i % 3 == 1) ? mem_pkg::sel_imm : mem_pkg::sel_pc4;
			send(1, 0, 0, 0, 0, mem_pkg::acc_w, sel, a, '0);
		end
		limit_val = 32'h80;
		end_test();

		begin_test("kill");
		for (int i = 0; i < 10; i++) begin
			send(1, 1, 0, 1, 0, mem_pkg::acc_w, mem_pkg::sel_alu, i * 4, $random(seed));
			send(1, 0, 1, 0, 0, mem_pkg::acc_w, mem_pkg::sel_load, i * 4, '0);
		end
		end_test();

		begin_test("stall");
		for (int i = 0; i < 10; i++) begin
			send(1, 0, 0, 0, 0, mem_pkg::acc_w, mem_pkg::sel_imm, '0, '0);
			send(0, 0, 0, 1, 0, mem_pkg::acc_w, mem_pkg::sel_alu, i * 4, $random(seed));
			send(1, 0, 1, 0, 0, mem_pkg::acc_w, mem_pkg::sel_load, i * 4, '0);
		end
		end_test();

		begin_test("bypass");
		for (int i = 10; i < 20; i++) begin
			send(1, 0, 0, 0, 0, mem_pkg::acc_w, mem_pkg::sel_imm, '0, '0);   // value to forward
			send(1, 0, 0, 1, 1, mem_pkg::acc_w, mem_pkg::sel_alu, i * 4, $random(seed));
			send(1, 0, 1, 0, 0, mem_pkg::acc_w, mem_pkg::sel_load, i * 4, '0);
		end
		end_test();

		// ------------------------------------------------------------------
		// random mix of every operation, stall and kill
		// ------------------------------------------------------------------

		begin_test("random");
		for (int i = 0; i < 400; i++) begin
			r   = $random(seed);
			acc = mem_pkg::access_t'(r[2:0] % 3'd5);
			a   = {$random(seed)} % (region_words * 4);
			if (acc == mem_pkg::acc_w) begin
				a[1:0] = 2'b00;
			end else if (acc inside {mem_pkg::acc_h, mem_pkg::acc_hu}) begin
				a[0] = 1'b0;
			end
			case (r[6:4])
				3'd0, 3'd1: sel = mem_pkg::sel_load;
				3'd5:       sel = mem_pkg::sel_imm;
				3'd6:       sel = mem_pkg::sel_pc4;
				default:    sel = mem_pkg::sel_alu;   // stores land here too
			endcase
			send(r[10:8] != 3'd0, r[15:12] == 4'd0, r[6:4] < 3'd2, r[6:4] inside {3'd2, 3'd3},
				r[16], acc, sel, a, $random(seed));
		end
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== mem_wb_top.f ====
+incdir+.
mem_pkg.sv
mem_ifs.sv
mem_stage.sv
data_mem.sv
wb_stage.sv
mem_wb_top.sv
tb_mem_wb_top.sv

// ==== Bender.yml ====
package:
  name: mem_wb_top

sources:
  - files:
      - mem_pkg.sv
      - mem_ifs.sv
      - mem_stage.sv
      - data_mem.sv
      - wb_stage.sv
      - mem_wb_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_mem_wb_top.sv
